// File: src/slm_cfg_pkg.sv
package slm_cfg_pkg;

    // ========================================================================
    // field widths of the sequencing configuration
    // ========================================================================

    // image count, up to 127 stored images
    localparam int NUM_IMAGES_W = 7;
    // frame memory slot index
    localparam int FRAME_W      = 6;
    // frame syncs per image
    localparam int CYCLES_W     = 16;
    // payload of a register write
    localparam int DATA_W       = 24;

    // ========================================================================
    // host command word
    // ========================================================================

    // top nibble of every host word
    // anything else is rejected by the register block
    typedef enum logic [3:0] {
        OP_WRITE_REG = 4'd1,
        OP_START_SEQ = 4'd2
    } host_op_t;

    // register map, one field per address
    typedef enum logic [3:0] {
        REG_NUM_IMAGES       = 4'd0,
        REG_FIRST_FRAME      = 4'd1,
        REG_CYCLES_PER_IMAGE = 4'd2,
        REG_STATIC_FRAME     = 4'd3
    } reg_addr_t;

    // register write view
    // value right-aligned in data, upper bits ignored
    typedef struct packed {
        host_op_t          opcode;
        reg_addr_t         addr;
        logic [DATA_W-1:0] data;
    } reg_write_t;

    // start view, nothing but the opcode matters
    typedef struct packed {
        host_op_t    opcode;
        logic [27:0] reserved;
    } start_cmd_t;

    // one 32-bit word, two readings picked by opcode
    typedef union packed {
        reg_write_t wr;
        start_cmd_t start_cmd;
    } host_word_t;

    // ========================================================================
    // live sequencing configuration
    // ========================================================================

    typedef struct packed {
        logic [NUM_IMAGES_W-1:0] num_images;
        logic [FRAME_W-1:0]      first_frame;
        logic [CYCLES_W-1:0]     cycles_per_image;
        logic [FRAME_W-1:0]      static_frame;
    } seq_cfg_t;

endpackage

// File: src/slm_disp_pkg.sv
package slm_disp_pkg;

    // frame memory slot shown on the modulator
    typedef logic [5:0] frame_id_t;

    // one digit, active low, bit 0 is segment a
    typedef logic [6:0] seg_t;

    // six digits of the board, leftmost first
    typedef struct packed {
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } hex_bank_t;

    // ========================================================================
    // segment patterns
    // ========================================================================

    localparam seg_t SEG_BLANK = 7'b1111111;

    // busy banner letters
    localparam seg_t SEG_b = 7'b0000011;
    localparam seg_t SEG_U = 7'b1000001;
    localparam seg_t SEG_S = 7'b0010010;
    localparam seg_t SEG_y = 7'b0010001;

    // hex nibble to digit, 0 through F
    localparam seg_t SEG_HEX [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    // debug byte selector, driven from the low switches
    // unlisted codes show zero
    typedef enum logic [7:0] {
        DBG_NUM_IMAGES  = 8'd0,
        DBG_FIRST_FRAME = 8'd1,
        DBG_CYCLES_LO   = 8'd2,
        DBG_CYCLES_HI   = 8'd3,
        DBG_START_CNT   = 8'd4,
        DBG_CAM_CNT     = 8'd5,
        DBG_FRAME_ID    = 8'd6
    } debug_sel_t;

endpackage

// File: src/host_reg_block.sv
`timescale 1ns/1ps

module host_reg_block #(
    parameter int unsigned RESET_CYCLES_PER_IMAGE = 4
) (
    input  logic                    CLOCK_50,
    input  logic                    delayed_reset,
    input  logic                    host_valid,
    input  slm_cfg_pkg::host_word_t host_word,
    output logic                    host_ready,
    input  logic                    busy,
    output slm_cfg_pkg::seq_cfg_t   cfg,
    output logic                    seq_start,
    output logic                    cmd_error
);

    // handshake completes on this edge
    logic                  accept;
    // decode results for the accepted word
    slm_cfg_pkg::seq_cfg_t cfg_next;
    logic                  start_hit;
    logic                  bad_word;

    // back-pressure while a run is active or just launched
    assign host_ready = !busy && !seq_start;
    assign accept     = host_valid && host_ready;

    // ========================================================================
    // word decode
    // ========================================================================

    // opcode picks the union view
    // register writes take only the low bits each field needs
    always_comb begin
        cfg_next  = cfg;
        start_hit = 1'b0;
        bad_word  = 1'b0;
        if (accept) begin
            case (host_word.start_cmd.opcode)
                slm_cfg_pkg::OP_WRITE_REG: begin
                    case (host_word.wr.addr)
                        slm_cfg_pkg::REG_NUM_IMAGES:
                            cfg_next.num_images =
                                host_word.wr.data[slm_cfg_pkg::NUM_IMAGES_W-1:0];
                        slm_cfg_pkg::REG_FIRST_FRAME:
                            cfg_next.first_frame =
                                host_word.wr.data[slm_cfg_pkg::FRAME_W-1:0];
                        slm_cfg_pkg::REG_CYCLES_PER_IMAGE:
                            cfg_next.cycles_per_image =
                                host_word.wr.data[slm_cfg_pkg::CYCLES_W-1:0];
                        slm_cfg_pkg::REG_STATIC_FRAME:
                            cfg_next.static_frame =
                                host_word.wr.data[slm_cfg_pkg::FRAME_W-1:0];
                        // unmapped address
                        default: bad_word = 1'b1;
                    endcase
                end
                slm_cfg_pkg::OP_START_SEQ: begin
                    // empty image list cannot run
                    if (cfg.num_images == '0) begin
                        bad_word = 1'b1;
                    end else begin
                        start_hit = 1'b1;
                    end
                end
                default: bad_word = 1'b1;
            endcase
        end
    end

    // ========================================================================
    // registers
    // ========================================================================

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            cfg <= '{
                num_images:       7'd1,
                first_frame:      '0,
                cycles_per_image: 16'(RESET_CYCLES_PER_IMAGE),
                static_frame:     '0
            };
            seq_start <= 1'b0;
            cmd_error <= 1'b0;
        end else begin
            // illegal words leave cfg untouched, see decode
            cfg       <= cfg_next;
            seq_start <= start_hit;
            // sticky until reset
            if (bad_word) begin
                cmd_error <= 1'b1;
            end
        end
    end

    // start pulse lands before the sequencer raises busy
    a_no_start_while_busy: assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        seq_start |-> !busy
    );

    // nothing is consumed while the host is held off
    a_no_accept_when_stalled: assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        !host_ready |=> ($stable(cfg) && !seq_start && $stable(cmd_error))
    );

endmodule

// File: src/frame_sequencer.sv
`timescale 1ns/1ps

module frame_sequencer (
    input  logic                     CLOCK_50,
    input  logic                     delayed_reset,
    input  slm_cfg_pkg::seq_cfg_t    cfg,
    input  logic                     seq_start,
    input  logic                     frame_sync,
    input  logic                     sw_override,
    input  slm_disp_pkg::frame_id_t  sw_frame,
    output logic                     busy,
    output logic                     cam_trigger,
    output slm_disp_pkg::frame_id_t  display_frame_id
);

    // position in the image list
    logic [slm_cfg_pkg::NUM_IMAGES_W-1:0] img_idx;
    // syncs spent on the current image
    logic [slm_cfg_pkg::CYCLES_W-1:0]     sync_cnt;
    // current image has had all its syncs
    logic                                 hold_done;
    // current image is the final one
    logic                                 last_image;
    // frame memory slot of the current image
    slm_disp_pkg::frame_id_t              seq_frame_id;

    // this sync completes the hold
    // a zero hold behaves as one sync
    assign hold_done  = (sync_cnt + 16'd1) >= cfg.cycles_per_image;
    assign last_image = img_idx == (cfg.num_images - 7'd1);

    // ========================================================================
    // image stepping
    // ========================================================================

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            busy        <= 1'b0;
            cam_trigger <= 1'b0;
            img_idx     <= '0;
            sync_cnt    <= '0;
        end else begin
            cam_trigger <= 1'b0;
            if (seq_start) begin
                // first image triggers the camera right away
                busy        <= 1'b1;
                cam_trigger <= 1'b1;
                img_idx     <= '0;
                sync_cnt    <= '0;
            end else if (busy && frame_sync) begin
                if (hold_done) begin
                    sync_cnt <= '0;
                    if (last_image) begin
                        // run over
                        busy <= 1'b0;
                    end else begin
                        img_idx     <= img_idx + 7'd1;
                        cam_trigger <= 1'b1;
                    end
                end else begin
                    sync_cnt <= sync_cnt + 16'd1;
                end
            end
        end
    end

    // ========================================================================
    // frame id selection
    // ========================================================================

    // six-bit add wraps modulo 64
    assign seq_frame_id = cfg.first_frame + img_idx[5:0];

    // sequence, then switch override, then host static id
    always_comb begin
        if (busy) begin
            display_frame_id = seq_frame_id;
        end else if (sw_override) begin
            display_frame_id = sw_frame;
        end else begin
            display_frame_id = cfg.static_frame;
        end
    end

    // camera fires only inside a run
    a_trigger_in_run: assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        cam_trigger |-> (busy || $rose(busy))
    );

    // host is stalled while busy, so the list length cannot shrink under us
    a_index_in_range: assert property (
        @(posedge CLOCK_50) disable iff (delayed_reset)
        busy |-> (img_idx < cfg.num_images)
    );

endmodule

// File: src/status_display.sv
`timescale 1ns/1ps

module status_display (
    input  logic                     CLOCK_50,
    input  logic                     delayed_reset,
    input  slm_cfg_pkg::seq_cfg_t    cfg,
    input  logic                     busy,
    input  logic                     seq_start,
    input  logic                     cam_trigger,
    input  logic                     cmd_error,
    input  slm_disp_pkg::frame_id_t  display_frame_id,
    input  logic                     debug_en,
    input  slm_disp_pkg::debug_sel_t debug_sel,
    output slm_disp_pkg::hex_bank_t  hex,
    output logic [9:0]               ledr
);

    // wrapping event counters
    logic [7:0] start_cnt;
    logic [7:0] cam_cnt;
    // byte shown on the two right digits
    logic [7:0] debug_byte;

    // ========================================================================
    // event counters
    // ========================================================================

    always_ff @(posedge CLOCK_50 or posedge delayed_reset) begin
        if (delayed_reset) begin
            start_cnt <= '0;
            cam_cnt   <= '0;
        end else begin
            if (seq_start) begin
                start_cnt <= start_cnt + 8'd1;
            end
            if (cam_trigger) begin
                cam_cnt <= cam_cnt + 8'd1;
            end
        end
    end

    // ========================================================================
    // debug byte mux
    // ========================================================================

    // narrow fields zero-extended
    always_comb begin
        debug_byte = 8'd0;
        if (debug_en) begin
            case (debug_sel)
                slm_disp_pkg::DBG_NUM_IMAGES:  debug_byte = {1'b0, cfg.num_images};
                slm_disp_pkg::DBG_FIRST_FRAME: debug_byte = {2'b00, cfg.first_frame};
                slm_disp_pkg::DBG_CYCLES_LO:   debug_byte = cfg.cycles_per_image[7:0];
                slm_disp_pkg::DBG_CYCLES_HI:   debug_byte = cfg.cycles_per_image[15:8];
                slm_disp_pkg::DBG_START_CNT:   debug_byte = start_cnt;
                slm_disp_pkg::DBG_CAM_CNT:     debug_byte = cam_cnt;
                slm_disp_pkg::DBG_FRAME_ID:    debug_byte = {2'b00, display_frame_id};
                default:                       debug_byte = 8'd0;
            endcase
        end
    end

    // ========================================================================
    // digits and leds
    // ========================================================================

    // banner on the left four digits during a run
    assign hex.hex5 = busy ? slm_disp_pkg::SEG_b : slm_disp_pkg::SEG_BLANK;
    assign hex.hex4 = busy ? slm_disp_pkg::SEG_U : slm_disp_pkg::SEG_BLANK;
    assign hex.hex3 = busy ? slm_disp_pkg::SEG_S : slm_disp_pkg::SEG_BLANK;
    assign hex.hex2 = busy ? slm_disp_pkg::SEG_y : slm_disp_pkg::SEG_BLANK;

    // debug byte in hex, reads 00 when debug is off
    assign hex.hex1 = slm_disp_pkg::SEG_HEX[debug_byte[7:4]];
    assign hex.hex0 = slm_disp_pkg::SEG_HEX[debug_byte[3:0]];

    // error, busy, camera strobe, spare, then frame id
    assign ledr = {cmd_error, busy, cam_trigger, 1'b0, display_frame_id};

endmodule

// File: src/slm_ctrl_top.sv
`timescale 1ns/1ps

module slm_ctrl_top #(
    parameter int unsigned RESET_CYCLES_PER_IMAGE = 4
) (
    input  logic                    CLOCK_50,
    input  logic                    delayed_reset,
    input  logic                    host_valid,
    input  slm_cfg_pkg::host_word_t host_word,
    output logic                    host_ready,
    input  logic [9:0]              sw,
    input  logic                    frame_sync,
    output slm_disp_pkg::frame_id_t display_frame_id,
    output logic [9:0]              ledr,
    output slm_disp_pkg::hex_bank_t hex
);

    // ========================================================================
    // internal nets
    // ========================================================================

    slm_cfg_pkg::seq_cfg_t cfg;
    logic                  seq_start;
    logic                  cmd_error;
    logic                  busy;
    logic                  cam_trigger;

    // host words in, configuration and start pulse out
    host_reg_block #(
        .RESET_CYCLES_PER_IMAGE(RESET_CYCLES_PER_IMAGE)
    ) u_host_reg_block (
        .CLOCK_50     (CLOCK_50),
        .delayed_reset(delayed_reset),
        .host_valid   (host_valid),
        .host_word    (host_word),
        .host_ready   (host_ready),
        .busy         (busy),
        .cfg          (cfg),
        .seq_start    (seq_start),
        .cmd_error    (cmd_error)
    );

    // sw[9] forces the switch frame id when idle
    frame_sequencer u_frame_sequencer (
        .CLOCK_50        (CLOCK_50),
        .delayed_reset   (delayed_reset),
        .cfg             (cfg),
        .seq_start       (seq_start),
        .frame_sync      (frame_sync),
        .sw_override     (sw[9]),
        .sw_frame        (sw[5:0]),
        .busy            (busy),
        .cam_trigger     (cam_trigger),
        .display_frame_id(display_frame_id)
    );

    // sw[8] enables debug, sw[7:0] picks the byte
    status_display u_status_display (
        .CLOCK_50        (CLOCK_50),
        .delayed_reset   (delayed_reset),
        .cfg             (cfg),
        .busy            (busy),
        .seq_start       (seq_start),
        .cam_trigger     (cam_trigger),
        .cmd_error       (cmd_error),
        .display_frame_id(display_frame_id),
        .debug_en        (sw[8]),
        .debug_sel       (slm_disp_pkg::debug_sel_t'(sw[7:0])),
        .hex             (hex),
        .ledr            (ledr)
    );

endmodule

// File: tb/tb_slm_ctrl.sv
`timescale 1ns/1ps

module tb_slm_ctrl;

    localparam int RESET_CYCLES = 4;
    // cycles any single wait may take
    localparam int TIMEOUT      = 200;

    // standard active-low hex digits with bit 0 as segment a
    localparam logic [6:0] DIGITS [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };
    // banner letters b U S y
    localparam logic [6:0] LET_B = 7'b0000011;
    localparam logic [6:0] LET_U = 7'b1000001;
    localparam logic [6:0] LET_S = 7'b0010010;
    localparam logic [6:0] LET_Y = 7'b0010001;

    logic                    CLOCK_50;
    logic                    delayed_reset;
    logic                    host_valid;
    slm_cfg_pkg::host_word_t host_word;
    logic                    host_ready;
    logic [9:0]              sw;
    logic                    frame_sync;
    slm_disp_pkg::frame_id_t display_frame_id;
    logic [9:0]              ledr;
    slm_disp_pkg::hex_bank_t hex;

    // reference model state
    int          m_num;
    int          m_cycles;
    int          m_idx;
    logic [5:0]  m_first;
    logic [5:0]  m_static;
    logic [7:0]  m_starts;
    logic [7:0]  m_cams;
    logic        m_busy;
    logic        m_error;

    logic [31:0] lfsr_state;
    logic [57:0] expect_vec;
    string       test_name;
    // compare request and answer
    int          cmp_seq = 0;
    int          cmp_ack = 0;
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          base_errors = 0;
    int          k;

    slm_ctrl_top #(
        .RESET_CYCLES_PER_IMAGE(RESET_CYCLES)
    ) dut (
        .CLOCK_50        (CLOCK_50),
        .delayed_reset   (delayed_reset),
        .host_valid      (host_valid),
        .host_word       (host_word),
        .host_ready      (host_ready),
        .sw              (sw),
        .frame_sync      (frame_sync),
        .display_frame_id(display_frame_id),
        .ledr            (ledr),
        .hex             (hex)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // ========================================================================
    // helpers
    // ========================================================================

    // fibonacci lfsr on taps 32 22 2 1
    // stepped once for every bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // expected {frame id, ledr, hex} from the model and switches
    function automatic logic [57:0] ref_outputs(input logic [9:0] sw_in);
        logic [5:0]  fid;
        logic [7:0]  dbg;
        logic [15:0] cyc;
        logic [27:0] banner;
        cyc = 16'(m_cycles);
        // sequence id first, then switch override, then static id
        if (m_busy) begin
            fid = m_first + 6'(m_idx);
        end else if (sw_in[9]) begin
            fid = sw_in[5:0];
        end else begin
            fid = m_static;
        end
        case (sw_in[7:0])
            8'd0: dbg = {1'b0, 7'(m_num)};
            8'd1: dbg = {2'b00, m_first};
            8'd2: dbg = cyc[7:0];
            8'd3: dbg = cyc[15:8];
            8'd4: dbg = m_starts;
            8'd5: dbg = m_cams;
            8'd6: dbg = {2'b00, fid};
            default: dbg = 8'd0;
        endcase
        if (!sw_in[8]) begin
            dbg = 8'd0;
        end
        banner = m_busy ? {LET_B, LET_U, LET_S, LET_Y} : {28{1'b1}};
        // camera strobe is always low at a snapshot
        return {fid, m_error, m_busy, 2'b00, fid, banner, DIGITS[dbg[7:4]], DIGITS[dbg[3:0]]};
    endfunction

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        n_checks++;
        if (expected !== actual) begin
            n_errors++;
            $display("mismatch %s %s: expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic abort_run(input string why);
        $display("error in %s: %s", test_name, why);
        $display("Regression failed");
        $finish;
    endtask

    // outputs compared half a cycle after the request
    always @(negedge CLOCK_50) begin
        if (cmp_ack != cmp_seq) begin
            expect_vec = ref_outputs(sw);
            check_value(test_name, "frame id", 64'(expect_vec[57:52]), 64'(display_frame_id));
            check_value(test_name, "ledr", 64'(expect_vec[51:42]), 64'(ledr));
            check_value(test_name, "hex", 64'(expect_vec[41:0]), 64'(hex));
            cmp_ack = cmp_seq;
        end
    end

    task automatic compare_now();
        int n;
        cmp_seq++;
        n = 0;
        while (cmp_ack != cmp_seq) begin
            if (n == TIMEOUT) begin
                abort_run("compare process never answered");
            end
            @(posedge CLOCK_50);
            #1;
            n++;
        end
    endtask

    task automatic end_test();
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, test_name, n_errors - base_errors);
        base_errors = n_errors;
    endtask

    task automatic reset_dut();
        delayed_reset = 1'b1;
        repeat (10) @(posedge CLOCK_50);
        #1;
        delayed_reset = 1'b0;
        m_num    = 1;
        m_cycles = RESET_CYCLES;
        m_idx    = 0;
        m_first  = '0;
        m_static = '0;
        m_starts = '0;
        m_cams   = '0;
        m_busy   = 1'b0;
        m_error  = 1'b0;
    endtask

    // hold the word until the handshake edge
    task automatic host_send(input logic [31:0] word);
        int n;
        host_valid = 1'b1;
        host_word  = word;
        n = 0;
        while (!host_ready) begin
            if (n == TIMEOUT) begin
                abort_run("host_ready stayed low");
            end
            @(posedge CLOCK_50);
            #1;
            n++;
        end
        @(posedge CLOCK_50);
        #1;
        host_valid = 1'b0;
    endtask

    // field takes the low data bits
    // unmapped address is an error
    task automatic write_reg(input logic [3:0] addr, input logic [23:0] data);
        host_send({slm_cfg_pkg::OP_WRITE_REG, addr, data});
        case (addr)
            4'd0: m_num = 32'(data[6:0]);
            4'd1: m_first = data[5:0];
            4'd2: m_cycles = 32'(data[15:0]);
            4'd3: m_static = data[5:0];
            default: m_error = 1'b1;
        endcase
    endtask

    task automatic wait_busy(input logic level, input string why);
        int n;
        n = 0;
        while (ledr[8] !== level) begin
            if (n == TIMEOUT) begin
                abort_run(why);
            end
            @(posedge CLOCK_50);
            #1;
            n++;
        end
    endtask

    // one more edge after busy rises lets the camera count settle
    task automatic after_start();
        wait_busy(1'b1, "busy never rose after a start");
        // first image strobes the camera together with busy
        check_value(test_name, "camera strobe", 64'd1, 64'(ledr[7]));
        @(posedge CLOCK_50);
        #1;
        m_busy   = 1'b1;
        m_idx    = 0;
        m_starts = m_starts + 8'd1;
        m_cams   = m_cams + 8'd1;
        compare_now();
    endtask

    task automatic start_run();
        host_send({slm_cfg_pkg::OP_START_SEQ, 28'd0});
        if (m_num == 0) begin
            m_error = 1'b1;
        end else begin
            after_start();
        end
    endtask

    // one sync per hold step with random gaps between them
    task automatic run_syncs();
        int img;
        int c;
        int gap;
        for (img = 0; img < m_num; img++) begin
            for (c = 0; c < m_cycles; c++) begin
                // a waiting host word must stay stalled
                if (host_valid) begin
                    check_value(test_name, "host_ready", 64'd0, 64'(host_ready));
                end
                gap = rand_bits(2);
                repeat (gap) begin
                    @(posedge CLOCK_50);
                    #1;
                end
                frame_sync = 1'b1;
                @(posedge CLOCK_50);
                #1;
                frame_sync = 1'b0;
                // strobe only when this sync opens the next image
                check_value(test_name, "camera strobe",
                            64'((c == m_cycles - 1) && (img != m_num - 1)), 64'(ledr[7]));
                @(posedge CLOCK_50);
                #1;
                if (c == m_cycles - 1) begin
                    if (img == m_num - 1) begin
                        wait_busy(1'b0, "busy never fell at the end of the run");
                        m_busy = 1'b0;
                    end else begin
                        m_idx++;
                        m_cams = m_cams + 8'd1;
                    end
                end
                compare_now();
            end
        end
    endtask

    // ========================================================================
    // tests
    // ========================================================================

    initial begin
        lfsr_state    = 32'hd590;
        delayed_reset = 1'b1;
        host_valid    = 1'b0;
        host_word     = '0;
        sw            = '0;
        frame_sync    = 1'b0;
        test_name     = "register writes";
        reset_dut();

        // reset values before random writes read back per selector
        compare_now();
        for (k = 0; k < 4; k++) begin
            write_reg(4'(k), 24'(rand_bits(24)));
        end
        for (k = 0; k < 8; k++) begin
            sw = {2'b01, 8'(k)};
            compare_now();
        end
        sw = {2'b00, 8'd2};
        compare_now();
        end_test();

        // each illegal kind from a clean state
        test_name = "illegal words";
        sw = {2'b01, 8'd4};
        for (k = 0; k < 3; k++) begin
            reset_dut();
            case (k)
                0: begin
                    host_send({4'd7, 28'h0abcdef});
                    m_error = 1'b1;
                end
                1: write_reg(4'd9, 24'h000015);
                default: begin
                    write_reg(4'd0, 24'd0);
                    start_run();
                end
            endcase
            // a start taken by mistake would show busy by now
            repeat (2) begin
                @(posedge CLOCK_50);
                #1;
            end
            compare_now();
        end
        end_test();

        // first frame near the top so the id wraps
        test_name = "sequence run";
        sw = {2'b01, 8'd5};
        write_reg(4'd0, 24'(1 + rand_bits(3)));
        write_reg(4'd2, 24'(1 + rand_bits(2)));
        write_reg(4'd1, 24'(60 + rand_bits(2)));
        start_run();
        run_syncs();
        end_test();

        test_name = "frame id select";
        sw = {1'b1, 3'b000, 6'(rand_bits(6))};
        compare_now();
        sw[9] = 1'b0;
        compare_now();
        write_reg(4'd3, 24'(rand_bits(24)));
        compare_now();
        // the running sequence wins over the switch override
        sw[9] = 1'b1;
        write_reg(4'd0, 24'd3);
        write_reg(4'd2, 24'd2);
        start_run();
        run_syncs();
        end_test();

        // second start waits out the first run
        test_name = "back-pressure";
        reset_dut();
        sw = {2'b01, 8'd4};
        write_reg(4'd0, 24'd2);
        write_reg(4'd2, 24'(1 + rand_bits(1)));
        start_run();
        host_word  = {slm_cfg_pkg::OP_START_SEQ, 28'd0};
        host_valid = 1'b1;
        run_syncs();
        host_valid = 1'b0;
        after_start();
        run_syncs();
        end_test();

        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: compile.f
src/slm_cfg_pkg.sv
src/slm_disp_pkg.sv
src/host_reg_block.sv
src/frame_sequencer.sv
src/status_display.sv
src/slm_ctrl_top.sv
tb/tb_slm_ctrl.sv

// File: Makefile
# Verilator build and regression run for the SLM control core

VERILATOR ?= verilator
TOP       ?= tb_slm_ctrl
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' compile.f)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when the file list or a source changes
$(BIN): compile.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f compile.f --top-module $(TOP) -Mdir obj_dir

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
